// File: icache_lines.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_lines import icache_pkg::*; (
    input  logic              clock,
    input  logic              reset,

    // Fetch lookup with port 0 as the older instruction
    input  logic [1:0]        i_read_valid,
    input  itag_t [1:0]       i_read_tag,
    output logic [1:0]        o_hit_valid,
    output mem_block_t [1:0]  o_hit_data,

    // Presence check for the miss request path
    input  itag_t             i_snoop_tag,
    output logic              o_snoop_found,

    // Block returned from memory
    input  logic              i_fill_valid,
    input  itag_t             i_fill_tag,
    input  mem_block_t        i_fill_data,

    icache_lru_if.store       lru
);

    localparam int LINES = `ICACHE_LINES;

    // Valid, tag and data per line
    logic [LINES-1:0] line_valid;
    itag_t            line_tag  [LINES];
    mem_block_t       line_data [LINES];

    // One match vector per read port
    logic [LINES-1:0] read_match [2];
    line_idx_t [1:0]  hit_idx;

    logic [LINES-1:0] snoop_match;

    logic             free_found;
    line_idx_t        free_idx;
    line_idx_t        fill_idx;

    // ---------------------------------------------------------------------------
    // Tag match
    // ---------------------------------------------------------------------------

    // Tags are unique among valid lines, so at most one line matches
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            read_match[p]  = '0;
            o_hit_valid[p] = 1'b0;
            o_hit_data[p]  = '0;
            hit_idx[p]     = '0;
            for (int i = 0; i < LINES; i++) begin
                if (i_read_valid[p] && line_valid[i] && line_tag[i] == i_read_tag[p]) begin
                    read_match[p][i] = 1'b1;
                    o_hit_valid[p]   = 1'b1;
                    o_hit_data[p]    = line_data[i];
                    hit_idx[p]       = line_idx_t'(i);
                end
            end
        end
    end

    // Snoop sees the same valid lines as the reads
    always_comb begin
        for (int i = 0; i < LINES; i++) begin
            snoop_match[i] = line_valid[i] && (line_tag[i] == i_snoop_tag);
        end
    end

    assign o_snoop_found = |snoop_match;

    // ---------------------------------------------------------------------------
    // Fill placement
    // ---------------------------------------------------------------------------

    // Descending scan leaves the lowest free line
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = LINES - 1; i >= 0; i--) begin
            if (!line_valid[i]) begin
                free_found = 1'b1;
                free_idx   = line_idx_t'(i);
            end
        end
    end

    // Evict only once every line is taken
    assign fill_idx = free_found ? free_idx : lru.victim_idx;

    // Report accesses to the replacement tree
    assign lru.hit_valid  = o_hit_valid;
    assign lru.hit_idx    = hit_idx;
    assign lru.fill_valid = i_fill_valid;
    assign lru.fill_idx   = fill_idx;

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (i_fill_valid) begin
            line_valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (i_fill_valid) begin
            line_tag[fill_idx]  <= i_fill_tag;
            line_data[fill_idx] <= i_fill_data;
        end
    end

    // Duplicate suppression upstream keeps each tag in one line,
    // so a read tag never matches two lines
    assert property (@(posedge clock) disable iff (reset)
        $onehot0(read_match[0]) && $onehot0(read_match[1]));

endmodule

`default_nettype wire

// File: icache_lru_if.sv
`timescale 1ns/1ps
`default_nettype none

interface icache_lru_if import icache_pkg::*; ();

    // Read hits, index 0 is the older fetch
    logic [1:0]      hit_valid;
    line_idx_t [1:0] hit_idx;

    // Line written by a memory fill
    logic            fill_valid;
    line_idx_t       fill_idx;

    // Line the tree would replace next
    line_idx_t       victim_idx;

    // Line store reports accesses and takes the victim
    modport store (
        output hit_valid, hit_idx, fill_valid, fill_idx,
        input  victim_idx
    );

    // Replacement policy only computes the victim
    modport policy (
        input  hit_valid, hit_idx, fill_valid, fill_idx,
        output victim_idx
    );

endinterface

`default_nettype wire

// File: icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// ---------------------------------------------------------------------------
// Cache geometry
// ---------------------------------------------------------------------------

// Fully associative lines, power of two for the PLRU tree
`define ICACHE_LINES 8

// Fetch address and block layout
`define ADDR_BITS 32
`define BLOCK_OFFSET_BITS 3
// Tag is addr[15:3], upper address bits expected zero
`define ITAG_BITS 13
`define MEM_BLOCK_BITS 64

// ---------------------------------------------------------------------------
// Memory side
// ---------------------------------------------------------------------------

// Tag zero means no transaction
`define MEM_TAG_BITS 4
// Outstanding miss entries, power of two so pointers wrap on their own
`define MSHR_DEPTH 16

`endif

// File: icache_pkg.sv
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

    // Fetch or memory request address
    typedef logic [`ADDR_BITS-1:0] i_addr_t;

    // Block tag, the address with offset and upper zero bits stripped
    typedef logic [`ITAG_BITS-1:0] itag_t;

    // Index of one cache line
    typedef logic [$clog2(`ICACHE_LINES)-1:0] line_idx_t;

    // One block of instruction data
    typedef logic [`MEM_BLOCK_BITS-1:0] mem_block_t;

    // Memory transaction tag, zero is no transaction
    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

    // Outstanding miss
    // mem_tag pairs the return with the block tag it fills
    typedef struct packed {
        logic     valid;
        mem_tag_t mem_tag;
        itag_t    i_tag;
    } mshr_entry_t;

endpackage

`default_nettype wire

// File: icache_subsystem.f
+incdir+.
icache_pkg.sv
icache_lru_if.sv
tree_plru.sv
icache_lines.sv
miss_fifo.sv
icache_subsystem.sv
tb_icache_subsystem.sv

// File: icache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_subsystem import icache_pkg::*; (
    input  logic             clock,
    input  logic             reset,

    // Fetch side, port 0 is the older instruction
    input  logic [1:0]       i_read_valid,
    input  i_addr_t [1:0]    i_read_addr,
    output logic [1:0]       o_hit_valid,
    output mem_block_t [1:0] o_hit_data,

    // Memory request
    output logic             o_mem_req_valid,
    output i_addr_t          o_mem_req_addr,
    input  logic             i_mem_req_accepted,
    input  mem_tag_t         i_mem_req_tag,

    // Memory return, nonzero tag marks data this cycle
    input  mem_tag_t         i_mem_data_tag,
    input  mem_block_t       i_mem_data
);

    itag_t [1:0]  read_tag;
    logic         miss_valid;
    itag_t        miss_tag;
    logic         found_cache;
    logic         found_mshr;
    mshr_entry_t  push_entry;
    logic         fill_valid;
    itag_t        fill_tag;

    icache_lru_if lru_bus ();

    // Strip the block offset, upper bits are assumed zero
    assign read_tag[0] = i_read_addr[0][`BLOCK_OFFSET_BITS +: `ITAG_BITS];
    assign read_tag[1] = i_read_addr[1][`BLOCK_OFFSET_BITS +: `ITAG_BITS];

    // ---------------------------------------------------------------------------
    // Miss request
    // ---------------------------------------------------------------------------

    // Older port first
    always_comb begin
        miss_valid = 1'b0;
        miss_tag   = read_tag[0];
        if (i_read_valid[0] && !o_hit_valid[0]) begin
            miss_valid = 1'b1;
        end else if (i_read_valid[1] && !o_hit_valid[1]) begin
            miss_valid = 1'b1;
            miss_tag   = read_tag[1];
        end
    end

    // Request only a block that is neither cached nor already in flight
    assign o_mem_req_valid = miss_valid && !found_cache && !found_mshr;

    always_comb begin
        o_mem_req_addr = '0;
        o_mem_req_addr[`BLOCK_OFFSET_BITS +: `ITAG_BITS] = miss_tag;
    end

    // Track the block once memory hands out a real tag
    always_comb begin
        push_entry         = '0;
        push_entry.valid   = o_mem_req_valid && i_mem_req_accepted && (i_mem_req_tag != '0);
        push_entry.mem_tag = i_mem_req_tag;
        push_entry.i_tag   = miss_tag;
    end

    icache_lines icache_lines_inst (
        .clock         (clock),
        .reset         (reset),
        .i_read_valid  (i_read_valid),
        .i_read_tag    (read_tag),
        .o_hit_valid   (o_hit_valid),
        .o_hit_data    (o_hit_data),
        .i_snoop_tag   (miss_tag),
        .o_snoop_found (found_cache),
        .i_fill_valid  (fill_valid),
        .i_fill_tag    (fill_tag),
        .i_fill_data   (i_mem_data),
        .lru           (lru_bus)
    );

    miss_fifo miss_fifo_inst (
        .clock          (clock),
        .reset          (reset),
        .i_snoop_tag    (miss_tag),
        .o_snoop_found  (found_mshr),
        .i_push         (push_entry),
        .i_mem_data_tag (i_mem_data_tag),
        .o_fill_valid   (fill_valid),
        .o_fill_tag     (fill_tag)
    );

    tree_plru tree_plru_inst (
        .clock (clock),
        .reset (reset),
        .lru   (lru_bus)
    );

endmodule

`default_nettype wire

// File: miss_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module miss_fifo import icache_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    // Presence check for the miss request path
    input  itag_t       i_snoop_tag,
    output logic        o_snoop_found,

    // Entry for an accepted request, valid bit marks the push
    input  mshr_entry_t i_push,

    // Memory return and the fill it produces
    input  mem_tag_t    i_mem_data_tag,
    output logic        o_fill_valid,
    output itag_t       o_fill_tag
);

    localparam int DEPTH    = `MSHR_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    mshr_entry_t         entries [DEPTH];
    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;

    logic [DEPTH-1:0]    snoop_match;
    logic                pop;

    // Any outstanding block counts, not just the head
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            snoop_match[i] = entries[i].valid && (entries[i].i_tag == i_snoop_tag);
        end
    end

    assign o_snoop_found = |snoop_match;

    // ---------------------------------------------------------------------------
    // In-order retire
    // ---------------------------------------------------------------------------

    // Only the head may retire, a return out of order is dropped
    assign pop = (i_mem_data_tag != '0) && entries[head].valid &&
                 (entries[head].mem_tag == i_mem_data_tag);

    assign o_fill_valid = pop;
    assign o_fill_tag   = entries[head].i_tag;

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else begin
            if (pop) begin
                entries[head].valid <= 1'b0;
                head                <= head + 1'b1;
            end
            // Push after pop, so a full queue refilling its head slot keeps the new entry
            if (i_push.valid) begin
                entries[tail] <= i_push;
                tail          <= tail + 1'b1;
            end
        end
    end

    // Tag space must never outrun the queue depth
    assert property (@(posedge clock) disable iff (reset)
        i_push.valid |-> (!entries[tail].valid || (pop && head == tail)));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_icache

verilator --binary --timing --assert \
    -f icache_subsystem.f \
    --top-module tb_icache_subsystem \
    -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "Result: FAIL"
    exit 1
fi

echo "Result: PASS"
exit 0

// File: tb_icache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module tb_icache_subsystem import icache_pkg::*; ();

    localparam int PERIOD        = 40;
    localparam int HALF_PERIOD   = PERIOD / 2;
    localparam int RESET_CYCLES  = 2;
    localparam int LINES         = `ICACHE_LINES;
    localparam int IDX_BITS      = $clog2(LINES);
    localparam int RANDOM_READS  = 20;
    // Cycles per test: reset miss, fill, suppression, ordering, replacement, back-pressure
    localparam int TEST_CYCLES   = 4 + 8 + 14 + 16 + 60 + 30;
    localparam int MARGIN_CYCLES = 50;

    logic             clock;
    logic             reset;
    logic [1:0]       rd_valid;
    i_addr_t [1:0]    rd_addr;
    logic [1:0]       hit_valid;
    mem_block_t [1:0] hit_data;
    logic             req_valid;
    i_addr_t          req_addr;
    logic             req_accepted;
    mem_tag_t         req_tag;
    mem_tag_t         data_tag;
    mem_block_t       data;

    // Reference model, lines plus PLRU tree plus outstanding misses
    logic [LINES-1:0] m_valid;
    itag_t            m_tag [LINES];
    mem_block_t       m_data [LINES];
    logic [LINES-2:0] m_tree;
    mem_tag_t         q_mem_tag [$];
    itag_t            q_itag [$];

    logic [31:0]      lcg_state = 32'h1ef2;
    int               errors;
    int               checks;
    int               tests_run;
    int               tests_failed;
    int               test_start_errors;
    string            test_name;

    icache_subsystem icache_subsystem_inst (
        .clock              (clock),
        .reset              (reset),
        .i_read_valid       (rd_valid),
        .i_read_addr        (rd_addr),
        .o_hit_valid        (hit_valid),
        .o_hit_data         (hit_data),
        .o_mem_req_valid    (req_valid),
        .o_mem_req_addr     (req_addr),
        .i_mem_req_accepted (req_accepted),
        .i_mem_req_tag      (req_tag),
        .i_mem_data_tag     (data_tag),
        .i_mem_data         (data)
    );

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic mem_block_t lcg_block();
        return {lcg_next(), lcg_next()};
    endfunction

    function automatic itag_t tag_of(input i_addr_t addr);
        return addr[`BLOCK_OFFSET_BITS +: `ITAG_BITS];
    endfunction

    function automatic i_addr_t block_addr(input itag_t tag);
        return i_addr_t'(tag) << `BLOCK_OFFSET_BITS;
    endfunction

    // ---------------------------------------------------------------------------
    // Reference model
    // ---------------------------------------------------------------------------

    // Line holding a tag, -1 if none
    function automatic int line_of(input itag_t tag);
        int found = -1;
        for (int i = 0; i < LINES; i++) begin
            if (m_valid[i] && m_tag[i] == tag) found = i;
        end
        return found;
    endfunction

    function automatic logic in_mshr(input itag_t tag);
        foreach (q_itag[i]) begin
            if (q_itag[i] == tag) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Root down, a node bit of 1 sends the walk right
    function automatic line_idx_t tree_victim();
        int        node = 0;
        line_idx_t idx = '0;
        for (int lvl = 0; lvl < IDX_BITS; lvl++) begin
            idx  = (idx << 1) | line_idx_t'(m_tree[node]);
            node = 2 * node + 1 + int'(m_tree[node]);
        end
        return idx;
    endfunction

    // Every ancestor turns away from the touched leaf
    function automatic void tree_touch(input line_idx_t idx);
        int node = 0;
        for (int lvl = IDX_BITS - 1; lvl >= 0; lvl--) begin
            m_tree[node] = !idx[lvl];
            node = 2 * node + 1 + int'(idx[lvl]);
        end
    endfunction

    // Expected hits, data and request for one pair of reads
    function automatic void ref_lookup(
        input  logic [1:0]       valid,
        input  i_addr_t [1:0]    addr,
        output logic [1:0]       exp_hit,
        output mem_block_t [1:0] exp_data,
        output logic             exp_req,
        output i_addr_t          exp_req_addr
    );
        int    idx;
        logic  miss_found = 1'b0;
        itag_t miss = '0;
        exp_hit  = '0;
        exp_data = '0;
        for (int p = 0; p < 2; p++) begin
            idx = line_of(tag_of(addr[p]));
            if (valid[p] && idx >= 0) begin
                exp_hit[p]  = 1'b1;
                exp_data[p] = m_data[idx];
            end else if (valid[p] && !miss_found) begin
                // Oldest miss wins even when it is already outstanding
                miss_found = 1'b1;
                miss       = tag_of(addr[p]);
            end
        end
        exp_req      = miss_found && !in_mshr(miss);
        exp_req_addr = block_addr(miss);
    endfunction

    // Advance the model by the coming rising edge
    function automatic void model_step();
        int               hit_line [2];
        int               fill_line = -1;
        logic             pop;
        logic [1:0]       exp_hit;
        mem_block_t [1:0] exp_data;
        logic             exp_req;
        i_addr_t          exp_addr;
        ref_lookup(rd_valid, rd_addr, exp_hit, exp_data, exp_req, exp_addr);
        for (int p = 0; p < 2; p++) begin
            hit_line[p] = exp_hit[p] ? line_of(tag_of(rd_addr[p])) : -1;
        end
        pop = data_tag != '0 && q_mem_tag.size() > 0 && q_mem_tag[0] == data_tag;
        if (pop) begin
            for (int i = 0; i < LINES; i++) begin
                if (fill_line < 0 && !m_valid[i]) fill_line = i;
            end
            if (fill_line < 0) fill_line = int'(tree_victim());
        end
        // Later touch wins: fill, then older read, then newer read
        if (fill_line >= 0) tree_touch(line_idx_t'(fill_line));
        if (hit_line[0] >= 0) tree_touch(line_idx_t'(hit_line[0]));
        if (hit_line[1] >= 0) tree_touch(line_idx_t'(hit_line[1]));
        if (pop) begin
            m_valid[fill_line] = 1'b1;
            m_tag[fill_line]   = q_itag[0];
            m_data[fill_line]  = data;
            void'(q_mem_tag.pop_front());
            void'(q_itag.pop_front());
        end
        if (exp_req && req_accepted && req_tag != '0) begin
            q_mem_tag.push_back(req_tag);
            q_itag.push_back(tag_of(exp_addr));
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Compare process, one sample just before each rising edge
    initial begin
        logic [1:0]       exp_hit;
        mem_block_t [1:0] exp_data;
        logic             exp_req;
        i_addr_t          exp_addr;
        forever begin
            @(negedge clock);
            #(HALF_PERIOD - 1);
            if (reset) begin
                m_valid = '0;
                m_tree  = '0;
                q_mem_tag.delete();
                q_itag.delete();
            end else begin
                ref_lookup(rd_valid, rd_addr, exp_hit, exp_data, exp_req, exp_addr);
                check_value("o_hit_valid", 64'(hit_valid), 64'(exp_hit));
                for (int p = 0; p < 2; p++) begin
                    if (exp_hit[p]) begin
                        check_value($sformatf("o_hit_data[%0d]", p), hit_data[p], exp_data[p]);
                    end
                end
                check_value("o_mem_req_valid", 64'(req_valid), 64'(exp_req));
                if (exp_req) check_value("o_mem_req_addr", 64'(req_addr), 64'(exp_addr));
                model_step();
            end
        end
    end

    // Watchdog sized from the test budget
    initial begin
        #(PERIOD * (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES));
        $display("Watchdog timeout, tests did not finish in time");
        $display("Test failed");
        $finish;
    end

    // ---------------------------------------------------------------------------
    // Stimulus helpers
    // ---------------------------------------------------------------------------

    task automatic drive_idle();
        rd_valid     = '0;
        rd_addr      = '0;
        req_accepted = 1'b0;
        req_tag      = '0;
        data_tag     = '0;
        data         = '0;
    endtask

    // One cycle of reads, returns mid-cycle for directed checks
    task automatic step(input logic [1:0] valid, input i_addr_t a0, input i_addr_t a1,
                        input logic accept, input mem_tag_t tag);
        @(negedge clock);
        drive_idle();
        rd_valid     = valid;
        rd_addr[0]   = a0;
        rd_addr[1]   = a1;
        req_accepted = accept;
        req_tag      = tag;
        #(HALF_PERIOD - 5);
    endtask

    task automatic mem_return(input mem_tag_t tag, input mem_block_t value);
        @(negedge clock);
        drive_idle();
        data_tag = tag;
        data     = value;
        #(HALF_PERIOD - 5);
    endtask

    // Miss, accept, return, then wait past the model update
    task automatic fill_block(input i_addr_t addr, input mem_tag_t tag, input mem_block_t value);
        step(2'b01, addr, '0, 1'b1, tag);
        mem_return(tag, value);
        #HALF_PERIOD;
    endtask

    task automatic begin_test(input string name);
        test_name         = name;
        test_start_errors = errors;
        tests_run++;
    endtask

    task automatic end_test();
        // Let the last compare of the test land first
        #HALF_PERIOD;
        if (errors != test_start_errors) begin
            tests_failed++;
            $display("[%0d] %s: %0d errors", tests_run, test_name, errors - test_start_errors);
        end else begin
            $display("[%0d] %s: pass", tests_run, test_name);
        end
    endtask

    // ---------------------------------------------------------------------------
    // Tests
    // ---------------------------------------------------------------------------

    initial begin
        i_addr_t    blocks [LINES];
        i_addr_t    cand;
        i_addr_t    first_addr;
        line_idx_t  victim;
        itag_t      victim_tag;
        logic [31:0] r;
        mem_block_t d_a;
        mem_block_t d_b;
        mem_block_t d_f;
        mem_block_t d_g;
        reset = 1'b1;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        d_a = lcg_block();
        d_b = lcg_block();
        d_f = lcg_block();
        d_g = lcg_block();
        blocks[0] = 32'h0000_1234;
        blocks[1] = 32'h0000_2000;
        blocks[2] = 32'h0000_5000;
        blocks[3] = 32'h0000_6018;

        begin_test("reset miss");
        step(2'b01, blocks[0], '0, 1'b0, '0);
        check_value("o_hit_valid", 64'(hit_valid), 64'd0);
        check_value("o_mem_req_valid", 64'(req_valid), 64'd1);
        check_value("o_mem_req_addr", 64'(req_addr), 64'h1230);
        end_test();

        begin_test("fill");
        step(2'b01, blocks[0], '0, 1'b1, 4'd3);
        mem_return(4'd3, d_a);
        step(2'b01, 32'h0000_1236, '0, 1'b0, '0);
        check_value("o_hit_valid", 64'(hit_valid), 64'd1);
        check_value("o_hit_data[0]", hit_data[0], d_a);
        end_test();

        begin_test("suppression");
        step(2'b01, blocks[1], '0, 1'b1, 4'd5);
        step(2'b01, blocks[1], '0, 1'b0, '0);
        check_value("o_mem_req_valid", 64'(req_valid), 64'd0);
        step(2'b11, 32'h0000_3008, 32'h0000_4010, 1'b0, '0);
        check_value("o_mem_req_addr", 64'(req_addr), 64'h3008);
        mem_return(4'd5, d_b);
        step(2'b01, blocks[1], '0, 1'b0, '0);
        check_value("o_mem_req_valid", 64'(req_valid), 64'd0);
        // Port 0 hits, so port 1's miss is requested
        step(2'b11, blocks[1], 32'h0000_4014, 1'b0, '0);
        check_value("o_mem_req_addr", 64'(req_addr), 64'h4010);
        end_test();

        begin_test("ordering");
        step(2'b01, blocks[2], '0, 1'b1, 4'd6);
        step(2'b01, blocks[3], '0, 1'b1, 4'd7);
        mem_return(4'd7, d_g);
        step(2'b11, blocks[2], blocks[3], 1'b0, '0);
        check_value("o_hit_valid", 64'(hit_valid), 64'd0);
        check_value("o_mem_req_valid", 64'(req_valid), 64'd0);
        mem_return(4'd6, d_f);
        mem_return(4'd7, d_g);
        step(2'b11, blocks[2], blocks[3], 1'b0, '0);
        check_value("o_hit_valid", 64'(hit_valid), 64'd3);
        check_value("o_hit_data[0]", hit_data[0], d_f);
        check_value("o_hit_data[1]", hit_data[1], d_g);
        end_test();

        begin_test("replacement");
        for (int i = 4; i < LINES; i++) begin
            cand = lcg_next() & 32'h0000_fff8;
            while (line_of(tag_of(cand)) >= 0) cand = lcg_next() & 32'h0000_fff8;
            blocks[i] = cand;
            fill_block(cand, mem_tag_t'(i + 4), lcg_block());
        end
        repeat (RANDOM_READS) begin
            r = lcg_next();
            step(r[1:0], blocks[r[4:2]] + i_addr_t'(r[7:5]), blocks[r[10:8]], 1'b0, '0);
        end
        #HALF_PERIOD;
        victim     = tree_victim();
        victim_tag = m_tag[victim];
        cand = lcg_next() & 32'h0000_fff8;
        while (line_of(tag_of(cand)) >= 0) cand = lcg_next() & 32'h0000_fff8;
        fill_block(cand, 4'd13, lcg_block());
        for (int i = 0; i < LINES; i++) begin
            step(2'b01, blocks[i], '0, 1'b0, '0);
            check_value($sformatf("o_hit_valid for block %h", blocks[i]), 64'(hit_valid[0]),
                        64'(tag_of(blocks[i]) != victim_tag));
        end
        step(2'b01, cand, '0, 1'b0, '0);
        check_value("o_hit_valid for ninth block", 64'(hit_valid[0]), 64'd1);
        end_test();

        begin_test("back-pressure");
        cand = lcg_next() & 32'h0000_fff8;
        while (line_of(tag_of(cand)) >= 0) cand = lcg_next() & 32'h0000_fff8;
        step(2'b01, cand + 32'd2, '0, 1'b0, '0);
        first_addr = req_addr;
        check_value("o_mem_req_addr", 64'(first_addr), 64'(cand));
        // Accept with tag zero tracks nothing either
        step(2'b01, cand + 32'd2, '0, 1'b1, '0);
        repeat (4) begin
            step(2'b01, cand + 32'd2, '0, 1'b0, '0);
            check_value("o_mem_req_valid", 64'(req_valid), 64'd1);
            check_value("o_mem_req_addr", 64'(req_addr), 64'(first_addr));
        end
        for (int t = 1; t < 16; t++) begin
            mem_return(mem_tag_t'(t), lcg_block());
        end
        step(2'b01, cand, '0, 1'b0, '0);
        check_value("o_hit_valid", 64'(hit_valid), 64'd0);
        check_value("o_mem_req_valid", 64'(req_valid), 64'd1);
        end_test();

        @(negedge clock);
        $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tree_plru.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module tree_plru import icache_pkg::*; (
    input logic          clock,
    input logic          reset,
    icache_lru_if.policy lru
);

    localparam int LINES     = `ICACHE_LINES;
    localparam int NODES     = LINES - 1;
    localparam int IDX_BITS  = $clog2(LINES);
    // Heap numbering covers nodes and leaves, up to 2*LINES-2
    localparam int NODE_BITS = $clog2(2 * LINES);
    // Select width into the node vector itself
    localparam int SEL_BITS  = $clog2(NODES);

    // Node bit 0 points left as the colder side, 1 points right
    logic [NODES-1:0] plru_tree;
    logic [NODES-1:0] plru_next;

    // Per-access path masks and the values written along them
    logic [NODES-1:0] new_mask;
    logic [NODES-1:0] new_val;
    logic [NODES-1:0] old_mask;
    logic [NODES-1:0] old_val;
    logic [NODES-1:0] fill_mask;
    logic [NODES-1:0] fill_val;

    logic [NODE_BITS-1:0] walk_node;

    // ---------------------------------------------------------------------------
    // Path from one leaf up to the root
    // ---------------------------------------------------------------------------

    // Each ancestor is turned away from the touched leaf.
    // A left child has an odd heap index, so its parent becomes 1
    function automatic void touch_path(
        input  line_idx_t        idx,
        input  logic             valid,
        output logic [NODES-1:0] mask,
        output logic [NODES-1:0] val
    );
        logic [NODE_BITS-1:0] node;
        logic [NODE_BITS-1:0] parent;
        mask = '0;
        val  = '0;
        node = NODE_BITS'(NODES) + NODE_BITS'(idx);
        for (int lvl = 0; lvl < IDX_BITS; lvl++) begin
            parent = (node - 1'b1) >> 1;
            if (valid) begin
                mask[SEL_BITS'(parent)] = 1'b1;
                val[SEL_BITS'(parent)]  = node[0];
            end
            node = parent;
        end
    endfunction

    // All three accesses resolved side by side
    always_comb begin
        touch_path(lru.hit_idx[1], lru.hit_valid[1], new_mask, new_val);
        touch_path(lru.hit_idx[0], lru.hit_valid[0], old_mask, old_val);
        touch_path(lru.fill_idx, lru.fill_valid, fill_mask, fill_val);
    end

    // ---------------------------------------------------------------------------
    // Merge per node
    // ---------------------------------------------------------------------------

    // Newer read wins, then older read, then the fill
    always_comb begin
        for (int i = 0; i < NODES; i++) begin
            if (new_mask[i]) begin
                plru_next[i] = new_val[i];
            end else if (old_mask[i]) begin
                plru_next[i] = old_val[i];
            end else if (fill_mask[i]) begin
                plru_next[i] = fill_val[i];
            end else begin
                plru_next[i] = plru_tree[i];
            end
        end
    end

    // ---------------------------------------------------------------------------
    // Victim walk
    // ---------------------------------------------------------------------------

    // Follow node bits from the root down to a leaf
    always_comb begin
        walk_node = '0;
        for (int lvl = 0; lvl < IDX_BITS; lvl++) begin
            if (plru_tree[SEL_BITS'(walk_node)]) begin
                walk_node = (walk_node << 1) + NODE_BITS'(2);
            end else begin
                walk_node = (walk_node << 1) + NODE_BITS'(1);
            end
        end
    end

    // Leaf heap index minus node count is the line
    assign lru.victim_idx = IDX_BITS'(walk_node - NODE_BITS'(NODES));

    always_ff @(posedge clock) begin
        if (reset) begin
            plru_tree <= '0;
        end else begin
            plru_tree <= plru_next;
        end
    end

endmodule

`default_nettype wire
